/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vector_issue
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), look for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_vector_issue.sv */
`timescale 1ns/1ps
`include "vec_params.svh"

module tb_vector_issue import vec_pkg::*; ();

	// Expected issue entry built from the RVV encoding
	typedef struct packed {
		slot_idx_t  id;
		logic       last;                   // Final entry of its convoy
		reg_idx_t   vd, vs1, vs2, rs1, uimm;
		funct6_t    funct6;
		alu_src_t   src;
		logic       mask_en;
	} exp_entry_t;

	typedef struct packed {
		instr_t  instr;
		logic    valid;
		logic    branch;
	} stim_t;

	logic        reset;                  // Clock
	logic        clk;                    // Async reset, active high
	instr_t      instr;
	logic        instr_valid, branch_taken;
	xdata_t      rs1_data;
	logic        exe_stall, exe_done;
	logic        v_stall, issue_start, issue_mask_en, exe_clear;
	reg_idx_t    rs_sel, issue_vd, issue_vs1, issue_vs2, issue_uimm5;
	slot_idx_t   issue_id;
	funct6_t     issue_funct6;
	alu_src_t    issue_alu_src;
	xdata_t      issue_rs1_data;

	integer      seed = 69;
	xdata_t      rf [32];                // Scalar register file model
	stim_t       stim_q [$];
	exp_entry_t  pend_q [$];             // Open convoy as the collector should see it
	exp_entry_t  sb_q [$];               // Closed convoys in issue order
	int          cycle_cnt = 0;
	int          cycle_limit = 0;
	int          convoys = 0;
	int          clears = 0;
	int          done_delay = 0;
	logic        checking = 0;
	logic        model_stall = 0;        // Expected v_stall
	logic        stall_at_edge = 0;      // v_stall seen before the coming edge
	logic        all_sent = 0;           // Last entry of convoy accepted
	logic        clear_due = 0;          // Expected exe_clear this cycle
	logic        hold_prev = 0;
	logic [63:0] prev_payload;
	logic [63:0] payload;

	vector_issue_top dut (.*);

	assign rs1_data = rf[rs_sel];        // Same-cycle XRF read
	assign payload  = {issue_id, issue_vd, issue_vs1, issue_vs2, issue_uimm5,
		issue_funct6, issue_alu_src, issue_mask_en, issue_rs1_data};

	initial begin
		reset = 0;
		forever #20 reset = ~reset;     // 40 ns period
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_field(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp)
			else report_failure($sformatf("error %s expected %h actual %h", name, exp, act));
	endtask

	function automatic alu_src_t src_of_funct3(input logic [2:0] f3);
		case (f3)
			3'b011:                 return `SRC_IMM;   // OPIVI
			3'b100, 3'b101, 3'b110: return `SRC_RS;    // OPIVX, OPFVF, OPMVX
			default:                return `SRC_VS;    // OPIVV, OPFVV, OPMVV
		endcase
	endfunction

	function automatic exp_entry_t decode_vec(input instr_t w);
		exp_entry_t e;
		e         = '0;
		e.funct6  = w[31:26];
		e.mask_en = !w[25];                 // vm=0 selects the masked form
		e.vs2     = w[24:20];
		e.vs1     = w[19:15];
		e.rs1     = w[19:15];
		e.uimm    = w[19:15];
		e.src     = src_of_funct3(w[14:12]);
		e.vd      = w[11:7];
		return e;
	endfunction

	// Kind 0 vector, 1 scalar, 2 taken branch, 3 bubble
	task automatic add_item(input int kind);
		stim_t s;
		s.instr  = $random(seed);
		s.valid  = (kind != 3);
		s.branch = (kind == 2);
		case (kind)
			0: begin
				s.instr[6:0]   = `OPCODE_OP_V;
				s.instr[14:12] = 3'($unsigned($random(seed)) % 7);   // No OPCFG
			end
			2:       s.instr[6:0] = 7'b1100011;    // BRANCH
			default: s.instr[6:0] = 7'b0110011;    // OP
		endcase
		stim_q.push_back(s);
	endtask

	task automatic close_convoy();
		exp_entry_t e;
		foreach (pend_q[i]) begin
			e      = pend_q[i];
			e.last = (i == pend_q.size() - 1);
			sb_q.push_back(e);
		end
		pend_q.delete();
		convoys++;
		model_stall = 1;                    // v_stall up from the closing edge
	endtask

	task automatic check_entry(input exp_entry_t e);
		check_field("issue_id", e.id, issue_id);
		check_field("issue_vd", e.vd, issue_vd);
		check_field("issue_vs1", e.vs1, issue_vs1);
		check_field("issue_vs2", e.vs2, issue_vs2);
		check_field("issue_uimm5", e.uimm, issue_uimm5);
		check_field("issue_funct6", e.funct6, issue_funct6);
		check_field("issue_alu_src", e.src, issue_alu_src);
		check_field("issue_mask_en", e.mask_en, issue_mask_en);
		check_field("rs_sel", e.rs1, rs_sel);
		check_field("issue_rs1_data", rf[e.rs1], issue_rs1_data);
	endtask

	////////////////////////////////////////
	// Stimulus and collector model
	////////////////////////////////////////
	initial begin
		int          r;
		int          idx;
		stim_t       s;
		exp_entry_t  e;
		clk          = 1;
		instr        = '0;
		instr_valid  = 0;
		branch_taken = 0;
		exe_stall    = 0;
		exe_done     = 0;
		foreach (rf[i]) rf[i] = $random(seed);
		repeat (3) add_item(0);             // Short convoy closed by a scalar instr
		add_item(1);
		repeat (9) add_item(0);             // Full convoy plus a ninth that waits
		add_item(1);
		repeat (2) add_item(0);             // Partial convoy killed by a branch
		add_item(2);
		add_item(0);
		add_item(1);
		repeat (60) begin
			r = $unsigned($random(seed)) % 20;
			add_item(r < 12 ? 0 : (r < 16 ? 1 : (r < 18 ? 3 : 2)));
		end
		add_item(1);                        // Flush whatever is still open
		cycle_limit = stim_q.size() * 20 + 200;
		repeat (5) @(posedge reset);
		#2 clk = 0;
		@(negedge reset);                   // Mid-cycle after reset release
		check_field("v_stall", 0, v_stall);
		check_field("issue_start", 0, issue_start);
		check_field("exe_clear", 0, exe_clear);
		@(posedge reset);
		#2;
		checking = 1;
		idx = 0;
		while (idx < stim_q.size()) begin
			s            = stim_q[idx];
			instr        = s.instr;
			instr_valid  = s.valid;
			branch_taken = s.branch;
			@(posedge reset);
			#2;
			if (!stall_at_edge) begin       // Collector was open on that edge
				if (s.branch) begin
					pend_q.delete();
					idx++;
				end else if (s.valid && s.instr[6:0] == `OPCODE_OP_V) begin
					e    = decode_vec(s.instr);
					e.id = slot_idx_t'(pend_q.size());
					pend_q.push_back(e);
					if (pend_q.size() == `VEC_SLOTS)
						close_convoy();
					idx++;
				end else if (s.valid && pend_q.size() != 0) begin
					close_convoy();         // Closer stays on the inputs
				end else begin
					idx++;
				end
			end
		end
		instr_valid  = 0;
		branch_taken = 0;
		while (sb_q.size() != 0 || model_stall) @(posedge reset);
		@(posedge reset);
		if (clears != convoys) begin
			report_failure($sformatf("exe_clear pulsed %0d times for %0d convoys",
				clears, convoys));
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

	// Execution unit model with random stall and done latency
	always @(posedge reset) begin
		#2;
		exe_stall = ($random(seed) & 3) == 0;
		if (all_sent && done_delay == 0)
			exe_done = 1;
		else begin
			exe_done = 0;
			if (all_sent) done_delay--;
		end
	end

	////////////////////////////////////////
	// Scoreboard sampled mid-cycle
	////////////////////////////////////////
	always @(negedge reset) begin
		if (checking) begin
			check_field("v_stall", model_stall, v_stall);
			if (hold_prev) begin            // Stalled last cycle
				check_field("issue_start", 1, issue_start);
				check_field("issue payload", prev_payload, payload);
			end
			if (issue_start && sb_q.size() == 0) begin
				report_failure("issue_start raised with no closed convoy waiting");
			end else if (issue_start) begin
				check_entry(sb_q[0]);
				if (!exe_stall) begin       // Accepted on the coming edge
					if (sb_q[0].last) begin
						all_sent   = 1;
						done_delay = $random(seed) & 3;
					end
					void'(sb_q.pop_front());
				end
			end
			check_field("exe_clear", clear_due, exe_clear);
			if (exe_clear) begin
				clears++;
				model_stall = 0;            // v_stall drops after release
			end
			clear_due = all_sent && exe_done;   // Done taken on the coming edge
			if (clear_due)
				all_sent = 0;
			hold_prev     = issue_start && exe_stall;
			prev_payload  = payload;
			stall_at_edge = v_stall;
		end
	end

	assert property (@(posedge reset) disable iff (clk) (issue_start && exe_stall) |=> issue_start)
		else report_failure("issue_start dropped while exe_stall was high");
	assert property (@(posedge reset) disable iff (clk) exe_clear |=> !exe_clear)
		else report_failure("exe_clear stayed high for more than one cycle");

	// Run limit
	always @(posedge reset) begin
		cycle_cnt++;
		if (cycle_limit != 0 && cycle_cnt > cycle_limit)
			report_failure($sformatf("timeout after %0d cycles, stimulus did not complete",
				cycle_cnt));
	end

endmodule

/* hdl/convoy_buffer.sv */
`timescale 1ns/1ps
`include "vec_params.svh"

module convoy_buffer import vec_pkg::*; (
	input  logic        reset,        // Clock
	input  logic        clk,          // Async reset, active high
	// Write side, from collector
	input  logic        wr_en,
	input  slot_idx_t   wr_slot,
	input  reg_idx_t    vd,
	input  reg_idx_t    vs1,
	input  reg_idx_t    vs2,
	input  reg_idx_t    rs1_idx,
	input  reg_idx_t    uimm5,
	input  funct6_t     funct6,
	input  alu_src_t    alu_src,
	input  logic        mask_en,
	input  logic        clear,        // Convoy release
	// Read side, to dispatcher
	input  slot_idx_t   rd_slot,
	output reg_idx_t    rd_vd,
	output reg_idx_t    rd_vs1,
	output reg_idx_t    rd_vs2,
	output reg_idx_t    rd_rs1_idx,
	output reg_idx_t    rd_uimm5,
	output funct6_t     rd_funct6,
	output alu_src_t    rd_alu_src,
	output logic        rd_mask_en
);

	// One packed entry per slot
	localparam int ENTRY_W = 5 * $bits(reg_idx_t) + $bits(funct6_t) + $bits(alu_src_t) + 1;

	logic [ENTRY_W-1:0] slots [`VEC_SLOTS];
	logic [ENTRY_W-1:0] wr_entry;

	assign wr_entry = {vd, vs1, vs2, rs1_idx, uimm5, funct6, alu_src, mask_en};

	////////////////////////////////////////
	// Slot registers
	////////////////////////////////////////
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			for (int i = 0; i < `VEC_SLOTS; i++)
				slots[i] <= '0;
		end else if (clear) begin           // Whole convoy gone at once
			for (int i = 0; i < `VEC_SLOTS; i++)
				slots[i] <= '0;
		end else if (wr_en) begin
			slots[wr_slot] <= wr_entry;
		end
	end

	// Combinational read, same packing order as the write
	assign {rd_vd, rd_vs1, rd_vs2, rd_rs1_idx, rd_uimm5,
		rd_funct6, rd_alu_src, rd_mask_en} = slots[rd_slot];

endmodule

/* hdl/convoy_dispatcher.sv */
`timescale 1ns/1ps

module convoy_dispatcher import vec_pkg::*; (
	input  logic          reset,            // Clock
	input  logic          clk,              // Async reset, active high
	// Handover from collector
	input  logic          convoy_ready,
	input  slot_count_t   convoy_len,
	// Entry under issue, from buffer
	input  reg_idx_t      rd_vd,
	input  reg_idx_t      rd_vs1,
	input  reg_idx_t      rd_vs2,
	input  reg_idx_t      rd_rs1_idx,
	input  reg_idx_t      rd_uimm5,
	input  funct6_t       rd_funct6,
	input  alu_src_t      rd_alu_src,
	input  logic          rd_mask_en,
	// Scalar register file
	input  xdata_t        rs1_data,
	// Execution unit status
	input  logic          exe_stall,
	input  logic          exe_done,
	output slot_idx_t     rd_slot,
	output reg_idx_t      rs_sel,
	// Issue port
	output logic          issue_start,
	output slot_idx_t     issue_id,
	output reg_idx_t      issue_vd,
	output reg_idx_t      issue_vs1,
	output reg_idx_t      issue_vs2,
	output reg_idx_t      issue_uimm5,
	output funct6_t       issue_funct6,
	output alu_src_t      issue_alu_src,
	output logic          issue_mask_en,
	output xdata_t        issue_rs1_data,
	output logic          exe_clear,
	output logic          convoy_release,
	output logic          v_stall           // Freezes scalar fetch
);

	dispatch_state_t  state;
	slot_count_t      disp_cnt;         // Next entry to send
	logic             accept;           // Entry taken this edge
	logic             last_entry;
	logic             release_pulse;

	assign accept        = issue_start && !exe_stall;
	assign last_entry    = (disp_cnt == convoy_len - 1'b1);
	assign release_pulse = (state == D_RELEASE);

	////////////////////////////////////////
	// Issue payload
	////////////////////////////////////////
	// Counter only moves on accept, so payload is steady under stall
	assign rd_slot        = slot_idx_t'(disp_cnt);
	assign issue_start    = (state == D_ISSUE);
	assign issue_id       = rd_slot;
	assign issue_vd       = rd_vd;
	assign issue_vs1      = rd_vs1;
	assign issue_vs2      = rd_vs2;
	assign issue_uimm5    = rd_uimm5;
	assign issue_funct6   = rd_funct6;
	assign issue_alu_src  = rd_alu_src;
	assign issue_mask_en  = rd_mask_en;
	assign rs_sel         = rd_rs1_idx;     // XRF read, same cycle
	assign issue_rs1_data = rs1_data;

	// Clear exe unit and free the buffer together
	assign exe_clear      = release_pulse;
	assign convoy_release = release_pulse;

	// High from convoy close through the release cycle
	assign v_stall = convoy_ready || (state != D_IDLE);

	////////////////////////////////////////
	// Dispatch FSM
	////////////////////////////////////////
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state    <= D_IDLE;
			disp_cnt <= '0;
		end else begin
			case (state)
				D_IDLE: begin
					if (convoy_ready) begin
						state    <= D_ISSUE;
						disp_cnt <= '0;
					end
				end
				D_ISSUE: begin
					if (accept) begin
						if (last_entry)
							state <= D_WAIT;            // Whole convoy handed over
						else
							disp_cnt <= disp_cnt + 1'b1;
					end
				end
				D_WAIT: if (exe_done) state <= D_RELEASE;
				D_RELEASE: begin
					state    <= D_IDLE;
					disp_cnt <= '0;
				end
				default: state <= D_IDLE;
			endcase
		end
	end

endmodule

/* hdl/vec_collector.sv */
`timescale 1ns/1ps
`include "vec_params.svh"

module vec_collector import vec_pkg::*; (
	input  logic           reset,           // Clock
	input  logic           clk,             // Async reset, active high
	input  instr_t         instr,           // From decode stage
	input  logic           instr_valid,
	input  logic           branch_taken,
	input  logic           convoy_release,  // Pulse from dispatcher
	output logic           wr_en,
	output slot_idx_t      wr_slot,
	output reg_idx_t       vd,
	output reg_idx_t       vs1,
	output reg_idx_t       vs2,
	output reg_idx_t       rs1_idx,
	output reg_idx_t       uimm5,
	output funct6_t        funct6,
	output alu_src_t       alu_src,
	output logic           mask_en,
	output logic           convoy_ready,
	output slot_count_t    convoy_len
);

	localparam slot_count_t LAST_SLOT = slot_count_t'(`VEC_SLOTS - 1);

	collect_state_t  state;
	slot_count_t     fill_cnt;          // Entries written into the open convoy
	logic            is_vec;
	logic [2:0]      funct3;

	////////////////////////////////////////
	// OP-V field decode
	////////////////////////////////////////
	assign is_vec  = instr_valid && (instr[6:0] == `OPCODE_OP_V);
	assign funct6  = instr[31:26];
	assign mask_en = ~instr[25];        // vm=0 means masked op
	assign vs2     = instr[24:20];
	assign vs1     = instr[19:15];      // Same bits serve as rs1 and imm
	assign rs1_idx = instr[19:15];
	assign uimm5   = instr[19:15];
	assign funct3  = instr[14:12];
	assign vd      = instr[11:7];

	// Operand category from funct3
	always_comb begin
		case (funct3)
			3'b011:                 alu_src = `SRC_IMM;    // OPIVI
			3'b100, 3'b101, 3'b110: alu_src = `SRC_RS;     // OPIVX, OPFVF, OPMVX
			default:                alu_src = `SRC_VS;     // Vector-vector forms
		endcase
	end

	// Write only while open, a branch kills the instr on that edge
	assign wr_en   = is_vec && (state != C_HELD) && !branch_taken;
	assign wr_slot = slot_idx_t'(fill_cnt);

	// Handover to dispatcher holds until release
	assign convoy_ready = (state == C_HELD);
	assign convoy_len   = fill_cnt;

	////////////////////////////////////////
	// Convoy FSM
	////////////////////////////////////////
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state    <= C_IDLE;
			fill_cnt <= '0;
		end else begin
			case (state)
				C_IDLE, C_COLLECT: begin
					if (branch_taken) begin             // Drop partial convoy
						state    <= C_IDLE;
						fill_cnt <= '0;
					end else if (wr_en) begin
						fill_cnt <= fill_cnt + 1'b1;
						if (fill_cnt == LAST_SLOT)
							state <= C_HELD;            // Buffer full
						else
							state <= C_COLLECT;
					end else if (instr_valid && (state == C_COLLECT)) begin
						state <= C_HELD;                // Scalar instr ends the run
					end
				end
				C_HELD: begin
					if (convoy_release) begin
						state    <= C_IDLE;
						fill_cnt <= '0;
					end
				end
				default: state <= C_IDLE;
			endcase
		end
	end

endmodule

/* hdl/vec_params.svh */
`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

////////////////////////////////////////
// Convoy geometry
////////////////////////////////////////
`define VEC_SLOTS    8            // Entries per convoy, power of two

// Instruction encoding
`define OPCODE_OP_V  7'b1010111   // Vector arithmetic major opcode

// Datapath widths
`define XLEN         32           // Scalar operand width
`define REG_IDX_W    5            // Register index and uimm5 width

// Operand source codes carried in alu_src
`define SRC_VS       2'b00        // Vector register vs1
`define SRC_RS       2'b01        // Scalar register rs1
`define SRC_IMM      2'b11        // Unsigned immediate

`endif

/* hdl/vec_pkg.sv */
`include "vec_params.svh"

package vec_pkg;

	////////////////////////////////////////
	// Datapath types
	////////////////////////////////////////
	typedef logic [31:0]             instr_t;      // Raw instruction word
	typedef logic [`XLEN-1:0]        xdata_t;      // Scalar operand
	typedef logic [`REG_IDX_W-1:0]   reg_idx_t;    // vd/vs1/vs2/rs1, also uimm5
	typedef logic [5:0]              funct6_t;     // Vector operation select
	typedef logic [1:0]              alu_src_t;    // vs / rs / uimm5

	// Slot bookkeeping
	typedef logic [$clog2(`VEC_SLOTS)-1:0] slot_idx_t;    // Slot number, issue ID
	typedef logic [$clog2(`VEC_SLOTS):0]   slot_count_t;  // 0..VEC_SLOTS filled

	////////////////////////////////////////
	// FSM states
	////////////////////////////////////////
	typedef enum logic [1:0] {
		C_IDLE,       // No convoy open
		C_COLLECT,    // Convoy open, taking vector instrs
		C_HELD        // Convoy closed, waiting for release
	} collect_state_t;

	typedef enum logic [1:0] {
		D_IDLE,       // Nothing to send
		D_ISSUE,      // Walking the buffer
		D_WAIT,       // All sent, waiting for exe_done
		D_RELEASE     // One cycle clear/release pulse
	} dispatch_state_t;

endpackage

/* hdl/vector_issue_top.sv */
`timescale 1ns/1ps

module vector_issue_top import vec_pkg::*; (
	input  logic        reset,            // Clock
	input  logic        clk,              // Async reset, active high
	input  instr_t      instr,
	input  logic        instr_valid,
	input  logic        branch_taken,
	input  xdata_t      rs1_data,
	input  logic        exe_stall,
	input  logic        exe_done,
	output logic        v_stall,
	output reg_idx_t    rs_sel,
	output logic        issue_start,
	output slot_idx_t   issue_id,
	output reg_idx_t    issue_vd,
	output reg_idx_t    issue_vs1,
	output reg_idx_t    issue_vs2,
	output reg_idx_t    issue_uimm5,
	output funct6_t     issue_funct6,
	output alu_src_t    issue_alu_src,
	output logic        issue_mask_en,
	output xdata_t      issue_rs1_data,
	output logic        exe_clear
);

	////////////////////////////////////////
	// Internal nets
	////////////////////////////////////////
	logic          wr_en;
	slot_idx_t     wr_slot;
	reg_idx_t      vd, vs1, vs2, rs1_idx, uimm5;
	funct6_t       funct6;
	alu_src_t      alu_src;
	logic          mask_en;
	logic          convoy_ready;
	slot_count_t   convoy_len;
	logic          convoy_release;    // Also clears the buffer
	slot_idx_t     rd_slot;
	reg_idx_t      rd_vd, rd_vs1, rd_vs2, rd_rs1_idx, rd_uimm5;
	funct6_t       rd_funct6;
	alu_src_t      rd_alu_src;
	logic          rd_mask_en;

	vec_collector u_collector (
		.reset(reset), .clk(clk),
		.instr(instr), .instr_valid(instr_valid), .branch_taken(branch_taken),
		.convoy_release(convoy_release),
		.wr_en(wr_en), .wr_slot(wr_slot),
		.vd(vd), .vs1(vs1), .vs2(vs2), .rs1_idx(rs1_idx), .uimm5(uimm5),
		.funct6(funct6), .alu_src(alu_src), .mask_en(mask_en),
		.convoy_ready(convoy_ready), .convoy_len(convoy_len)
	);

	convoy_buffer u_buffer (
		.reset(reset), .clk(clk),
		.wr_en(wr_en), .wr_slot(wr_slot),
		.vd(vd), .vs1(vs1), .vs2(vs2), .rs1_idx(rs1_idx), .uimm5(uimm5),
		.funct6(funct6), .alu_src(alu_src), .mask_en(mask_en),
		.clear(convoy_release),
		.rd_slot(rd_slot),
		.rd_vd(rd_vd), .rd_vs1(rd_vs1), .rd_vs2(rd_vs2), .rd_rs1_idx(rd_rs1_idx),
		.rd_uimm5(rd_uimm5), .rd_funct6(rd_funct6), .rd_alu_src(rd_alu_src),
		.rd_mask_en(rd_mask_en)
	);

	convoy_dispatcher u_dispatcher (
		.reset(reset), .clk(clk),
		.convoy_ready(convoy_ready), .convoy_len(convoy_len),
		.rd_vd(rd_vd), .rd_vs1(rd_vs1), .rd_vs2(rd_vs2), .rd_rs1_idx(rd_rs1_idx),
		.rd_uimm5(rd_uimm5), .rd_funct6(rd_funct6), .rd_alu_src(rd_alu_src),
		.rd_mask_en(rd_mask_en),
		.rs1_data(rs1_data), .exe_stall(exe_stall), .exe_done(exe_done),
		.rd_slot(rd_slot), .rs_sel(rs_sel),
		.issue_start(issue_start), .issue_id(issue_id),
		.issue_vd(issue_vd), .issue_vs1(issue_vs1), .issue_vs2(issue_vs2),
		.issue_uimm5(issue_uimm5), .issue_funct6(issue_funct6),
		.issue_alu_src(issue_alu_src), .issue_mask_en(issue_mask_en),
		.issue_rs1_data(issue_rs1_data),
		.exe_clear(exe_clear), .convoy_release(convoy_release),
		.v_stall(v_stall)
	);

endmodule

/* sources.f */
+incdir+hdl
hdl/vec_pkg.sv
hdl/vec_collector.sv
hdl/convoy_buffer.sv
hdl/convoy_dispatcher.sv
hdl/vector_issue_top.sv
bench/tb_vector_issue.sv
